// ==== hw/letc_core_params.svh ====
//////////////////////////////////////////////////
// Widths and CSR addresses shared by RTL and testbench
// Counters wrap at LETC_CNT_W bits
//////////////////////////////////////////////////

`ifndef LETC_CORE_PARAMS_SVH
`define LETC_CORE_PARAMS_SVH

// Architectural data width
`define LETC_XLEN 32

// Register index width, 32 architectural registers
`define LETC_REG_IDX_W 5

// Width of the cycle and instret counters
`define LETC_CNT_W 32

// Read-only user counter CSRs
`define LETC_CSR_CYCLE 12'hC00
`define LETC_CSR_INSTRET 12'hC02

`endif

// ==== hw/riscv_pkg.sv ====
//////////////////////////////////////////////////
// ISA level types for the RV32I subset in use
// Only the opcodes and funct3 codes the core decodes
//////////////////////////////////////////////////

`include "letc_core_params.svh"

package riscv_pkg;

    // Data or instruction word
    typedef logic [`LETC_XLEN-1:0] word_t;

    // Architectural register index
    typedef logic [`LETC_REG_IDX_W-1:0] reg_idx_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPCODE_OP_IMM = 7'b0010011,
        OPCODE_OP     = 7'b0110011,
        OPCODE_SYSTEM = 7'b1110011
    } opcode_t;

    // Minor opcodes, instr[14:12]
    // CSRRS only meaningful under SYSTEM
    typedef enum logic [2:0] {
        FUNCT3_ADD_SUB = 3'b000,
        FUNCT3_SLL     = 3'b001,
        FUNCT3_CSRRS   = 3'b010,
        FUNCT3_XOR     = 3'b100,
        FUNCT3_SRL     = 3'b101,
        FUNCT3_OR      = 3'b110,
        FUNCT3_AND     = 3'b111
    } funct3_t;

    // instr[31:25] for OP and the immediate shifts
    localparam logic [6:0] FUNCT7_BASE = 7'h00;
    // Selects SUB over ADD
    localparam logic [6:0] FUNCT7_ALT  = 7'h20;

endpackage : riscv_pkg

// ==== hw/letc_core_pkg.sv ====
//////////////////////////////////////////////////
// Microarchitecture types of the multicycle core
//////////////////////////////////////////////////

`include "letc_core_params.svh"

package letc_core_pkg;

    // 12-bit CSR address from instr[31:20]
    typedef logic [11:0] csr_idx_t;

    // Counter value, wraps
    typedef logic [`LETC_CNT_W-1:0] cnt_t;

    // One instruction in flight, four steps
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        DECODE    = 2'd1,
        EXECUTE   = 2'd2,
        WRITEBACK = 2'd3
    } seq_state_t;

    // ALU operations
    typedef enum logic [3:0] {
        ALU_ADD      = 4'd0,
        ALU_SUB      = 4'd1,
        ALU_XOR      = 4'd2,
        ALU_OR       = 4'd3,
        ALU_AND      = 4'd4,
        ALU_SLL      = 4'd5,
        ALU_SRL      = 4'd6,
        // Forward the selected CSR value
        ALU_PASS_CSR = 4'd7
    } alu_op_t;

endpackage : letc_core_pkg

// ==== hw/letc_core_sequencer.sv ====
//////////////////////////////////////////////////
// Strobe is ignored while busy, no back-pressure
// Retire comes 3 edges after acceptance
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "letc_core_params.svh"

module letc_core_sequencer
    import riscv_pkg::*;
    import letc_core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    // Instruction in
    input  logic     instr_valid,
    input  word_t    instr,
    output logic     busy,

    // Register file read
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,

    // ALU control
    output alu_op_t  alu_op,
    output logic     use_imm,
    output word_t    imm,
    output logic     alu_en,
    output csr_idx_t csr_idx,
    input  word_t    alu_result,

    // Register file write
    output logic     rd_wen,
    output reg_idx_t rd_idx,
    output word_t    rd_val,

    // Counter trigger
    output logic     instret_inc,

    // Retire report
    output logic     retire,
    output logic     retire_illegal,
    output reg_idx_t retire_rd_idx,
    output word_t    retire_rd_val
);

seq_state_t state;
word_t      instr_q;
logic       legal_q;

// Decoder outputs, captured at the end of DECODE
alu_op_t    dec_op;
logic       dec_use_imm;
word_t      dec_imm;
logic       dec_legal;

// Instruction fields
logic [6:0] funct7;
reg_idx_t   rs1_field;
csr_idx_t   csr_field;

assign funct7    = instr_q[31:25];
assign rs1_field = instr_q[19:15];
assign csr_field = instr_q[31:20];

always_comb begin
    dec_op      = ALU_ADD;
    dec_use_imm = 1'b0;
    // I-type immediate, sign extended
    dec_imm     = {{(`LETC_XLEN-12){instr_q[31]}}, instr_q[31:20]};
    dec_legal   = 1'b0;
    case (opcode_t'(instr_q[6:0]))
        OPCODE_OP_IMM: begin
            dec_use_imm = 1'b1;
            case (funct3_t'(instr_q[14:12]))
                FUNCT3_ADD_SUB: begin
                    dec_op    = ALU_ADD;
                    dec_legal = 1'b1;
                end
                FUNCT3_XOR: begin
                    dec_op    = ALU_XOR;
                    dec_legal = 1'b1;
                end
                FUNCT3_OR: begin
                    dec_op    = ALU_OR;
                    dec_legal = 1'b1;
                end
                FUNCT3_AND: begin
                    dec_op    = ALU_AND;
                    dec_legal = 1'b1;
                end
                // Shift amount in imm[4:0], upper bits must be clear
                FUNCT3_SLL: begin
                    dec_op    = ALU_SLL;
                    dec_legal = (funct7 == FUNCT7_BASE);
                end
                // SRAI has funct7 20 hex and stays illegal
                FUNCT3_SRL: begin
                    dec_op    = ALU_SRL;
                    dec_legal = (funct7 == FUNCT7_BASE);
                end
                default: dec_legal = 1'b0;
            endcase
        end
        OPCODE_OP: begin
            case (funct3_t'(instr_q[14:12]))
                FUNCT3_ADD_SUB: begin
                    dec_op    = (funct7 == FUNCT7_ALT) ? ALU_SUB : ALU_ADD;
                    dec_legal = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
                end
                FUNCT3_XOR: begin
                    dec_op    = ALU_XOR;
                    dec_legal = (funct7 == FUNCT7_BASE);
                end
                FUNCT3_OR: begin
                    dec_op    = ALU_OR;
                    dec_legal = (funct7 == FUNCT7_BASE);
                end
                FUNCT3_AND: begin
                    dec_op    = ALU_AND;
                    dec_legal = (funct7 == FUNCT7_BASE);
                end
                // Register shifts not in the subset
                default: dec_legal = 1'b0;
            endcase
        end
        OPCODE_SYSTEM: begin
            // Read only CSRRS rd, csr, x0 on a known counter
            dec_op    = ALU_PASS_CSR;
            dec_legal = (funct3_t'(instr_q[14:12]) == FUNCT3_CSRRS) &&
                        (rs1_field == '0) &&
                        ((csr_field == `LETC_CSR_CYCLE) || (csr_field == `LETC_CSR_INSTRET));
        end
        default: dec_legal = 1'b0;
    endcase
end

// State and legal flag
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state   <= IDLE;
        legal_q <= 1'b0;
    end else begin
        case (state)
            IDLE: begin
                if (instr_valid) begin
                    state <= DECODE;
                end
            end
            DECODE: begin
                state   <= EXECUTE;
                legal_q <= dec_legal;
            end
            EXECUTE:   state <= WRITEBACK;
            WRITEBACK: state <= IDLE;
            default:   state <= IDLE;
        endcase
    end
end

// Instruction and decoded payload
always_ff @(posedge clk) begin
    if ((state == IDLE) && instr_valid) begin
        instr_q <= instr;
    end
    if (state == DECODE) begin
        alu_op  <= dec_op;
        use_imm <= dec_use_imm;
        imm     <= dec_imm;
    end
end

assign busy    = (state != IDLE);
assign rs1_idx = rs1_field;
assign rs2_idx = instr_q[24:20];
assign csr_idx = csr_field;
assign alu_en  = (state == EXECUTE);

// Write back, suppressed when illegal
assign rd_idx      = instr_q[11:7];
assign rd_val      = alu_result;
assign rd_wen      = (state == WRITEBACK) && legal_q;
assign instret_inc = (state == WRITEBACK) && legal_q;

// Retire report, zero rd and value when illegal
assign retire         = (state == WRITEBACK);
assign retire_illegal = retire && !legal_q;
assign retire_rd_idx  = legal_q ? rd_idx : '0;
assign retire_rd_val  = legal_q ? rd_val : '0;

endmodule : letc_core_sequencer

// ==== hw/letc_core_counters.sv ====
//////////////////////////////////////////////////
// cycle and instret counters, wrap silently
// Unknown CSR addresses read as zero
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "letc_core_params.svh"

module letc_core_counters
    import letc_core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    // One pulse per legal retire
    input  logic     instret_inc,

    // CSR read port
    input  csr_idx_t csr_idx,
    output cnt_t     csr_rdata
);

cnt_t cycle_cnt;
cnt_t instret_cnt;

// Free running from reset release
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        cycle_cnt <= '0;
    end else begin
        cycle_cnt <= cycle_cnt + 1'b1;
    end
end

// Counts on the retire edge
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        instret_cnt <= '0;
    end else if (instret_inc) begin
        instret_cnt <= instret_cnt + 1'b1;
    end
end

// Read mux by CSR address
always_comb begin
    case (csr_idx)
        `LETC_CSR_CYCLE:   csr_rdata = cycle_cnt;
        `LETC_CSR_INSTRET: csr_rdata = instret_cnt;
        default:           csr_rdata = '0;
    endcase
end

endmodule : letc_core_counters

// ==== hw/letc_core_rf.sv ====
//////////////////////////////////////////////////
// 32 x 32 register file, x0 hardwired to zero
// Combinational reads, write lands on next edge
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "letc_core_params.svh"

module letc_core_rf
    import riscv_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    // Read ports
    input  reg_idx_t rs1_idx,
    output word_t    rs1_val,
    input  reg_idx_t rs2_idx,
    output word_t    rs2_val,

    // Write port
    input  logic     rd_wen,
    input  reg_idx_t rd_idx,
    input  word_t    rd_val
);

localparam int NUM_REGS = 2 ** `LETC_REG_IDX_W;

word_t regs [NUM_REGS];

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
        end
    end else if (rd_wen && (rd_idx != '0)) begin
        // x0 writes dropped
        regs[rd_idx] <= rd_val;
    end
end

// x0 reads forced to zero
assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule : letc_core_rf

// ==== hw/letc_core_alu.sv ====
//////////////////////////////////////////////////
// Result registered on the edge where alu_en is high
// Shifts use only the low 5 bits of operand b
//////////////////////////////////////////////////

`timescale 1ns/1ps

module letc_core_alu
    import riscv_pkg::*;
    import letc_core_pkg::*;
(
    input  logic    clk,
    input  logic    arst_n,

    // Control from the sequencer
    input  logic    alu_en,
    input  alu_op_t alu_op,
    input  logic    use_imm,
    input  word_t   imm,

    // Operands
    input  word_t   rs1_val,
    input  word_t   rs2_val,
    input  cnt_t    csr_rdata,

    output word_t   alu_result
);

word_t      opnd_b;
word_t      result_next;
logic [4:0] shamt;

// Immediate for OP-IMM, rs2 otherwise
assign opnd_b = use_imm ? imm : rs2_val;
assign shamt  = opnd_b[4:0];

always_comb begin
    case (alu_op)
        ALU_ADD:      result_next = rs1_val + opnd_b;
        ALU_SUB:      result_next = rs1_val - opnd_b;
        ALU_XOR:      result_next = rs1_val ^ opnd_b;
        ALU_OR:       result_next = rs1_val | opnd_b;
        ALU_AND:      result_next = rs1_val & opnd_b;
        ALU_SLL:      result_next = rs1_val << shamt;
        // Logical, zero fill
        ALU_SRL:      result_next = rs1_val >> shamt;
        // Counter value sampled in EXECUTE
        ALU_PASS_CSR: result_next = csr_rdata;
        default:      result_next = '0;
    endcase
end

// Held until the next EXECUTE
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        alu_result <= '0;
    end else if (alu_en) begin
        alu_result <= result_next;
    end
end

endmodule : letc_core_alu

// ==== hw/letc_core_top.sv ====
//////////////////////////////////////////////////
// One instruction in flight, no fetch or memory
// instr_valid is dropped while busy is high
//////////////////////////////////////////////////

`timescale 1ns/1ps

module letc_core_top
    import riscv_pkg::*;
    import letc_core_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,

    // Instruction in
    input  logic     instr_valid,
    input  word_t    instr,
    output logic     busy,

    // Retire report
    output logic     retire,
    output logic     retire_illegal,
    output reg_idx_t retire_rd_idx,
    output word_t    retire_rd_val
);

// Register file read
reg_idx_t rs1_idx;
reg_idx_t rs2_idx;
word_t    rs1_val;
word_t    rs2_val;

// Register file write
logic     rd_wen;
reg_idx_t rd_idx;
word_t    rd_val;

// ALU control and result
alu_op_t  alu_op;
logic     use_imm;
word_t    imm;
logic     alu_en;
word_t    alu_result;

// Counters
csr_idx_t csr_idx;
cnt_t     csr_rdata;
logic     instret_inc;

letc_core_sequencer sequencer (
    .clk            (clk),
    .arst_n         (arst_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .busy           (busy),
    .rs1_idx        (rs1_idx),
    .rs2_idx        (rs2_idx),
    .alu_op         (alu_op),
    .use_imm        (use_imm),
    .imm            (imm),
    .alu_en         (alu_en),
    .csr_idx        (csr_idx),
    .alu_result     (alu_result),
    .rd_wen         (rd_wen),
    .rd_idx         (rd_idx),
    .rd_val         (rd_val),
    .instret_inc    (instret_inc),
    .retire         (retire),
    .retire_illegal (retire_illegal),
    .retire_rd_idx  (retire_rd_idx),
    .retire_rd_val  (retire_rd_val)
);

letc_core_counters counters (
    .clk         (clk),
    .arst_n      (arst_n),
    .instret_inc (instret_inc),
    .csr_idx     (csr_idx),
    .csr_rdata   (csr_rdata)
);

letc_core_rf rf (
    .clk     (clk),
    .arst_n  (arst_n),
    .rs1_idx (rs1_idx),
    .rs1_val (rs1_val),
    .rs2_idx (rs2_idx),
    .rs2_val (rs2_val),
    .rd_wen  (rd_wen),
    .rd_idx  (rd_idx),
    .rd_val  (rd_val)
);

letc_core_alu alu (
    .clk        (clk),
    .arst_n     (arst_n),
    .alu_en     (alu_en),
    .alu_op     (alu_op),
    .use_imm    (use_imm),
    .imm        (imm),
    .rs1_val    (rs1_val),
    .rs2_val    (rs2_val),
    .csr_rdata  (csr_rdata),
    .alu_result (alu_result)
);

endmodule : letc_core_top

// ==== testbench/letc_core_props.sv ====
//////////////////////////////////////////////////
// Bound into letc_core_top, watches retire timing
//////////////////////////////////////////////////

`timescale 1ns/1ps

module letc_core_props
    import riscv_pkg::*;
(
    input logic  clk,
    input logic  arst_n,
    input logic  instr_valid,
    input logic  busy,
    input logic  retire,
    input logic  retire_illegal,
    input word_t retire_rd_val
);

logic accept;

// Strobe only counts while idle
assign accept = instr_valid && !busy;

// Single-cycle retire pulse
retire_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
    retire |=> !retire)
    else $error("retire held high for two cycles");

// Acceptance edge plus 3
retire_latency: assert property (@(posedge clk) disable iff (!arst_n)
    accept |-> ##3 retire)
    else $error("retire did not follow acceptance after 3 edges");

// Idle on the first edge after reset release
idle_after_reset: assert property (@(posedge clk)
    $rose(arst_n) |-> !busy)
    else $error("busy high right after reset");

// Illegal retires carry no value
illegal_zero_value: assert property (@(posedge clk) disable iff (!arst_n)
    (retire && retire_illegal) |-> (retire_rd_val == '0))
    else $error("illegal retire with nonzero value");

endmodule : letc_core_props

bind letc_core_top letc_core_props i_props (
    .clk            (clk),
    .arst_n         (arst_n),
    .instr_valid    (instr_valid),
    .busy           (busy),
    .retire         (retire),
    .retire_illegal (retire_illegal),
    .retire_rd_val  (retire_rd_val)
);

// ==== testbench/letc_core_tb.sv ====
//////////////////////////////////////////////////
// Inputs change and outputs are sampled on the falling edge
// Expected values assume one instruction in flight
//////////////////////////////////////////////////

`timescale 1ns/1ps

`include "letc_core_params.svh"

module letc_core_tb
    import riscv_pkg::*;
    import letc_core_pkg::*;
();

localparam int N_RAND_IMM = 40;
localparam int N_RAND_OP  = 40;
// Upper bound on directed instructions
localparam int N_DIRECTED = 32;
localparam int NUM_INSTR  = N_RAND_IMM + N_RAND_OP + N_DIRECTED;
localparam int TIMEOUT_CYCLES = 6 * NUM_INSTR + 100;

// Legal funct3 codes for the random loops
localparam logic [2:0] IMM_F3 [6] = '{3'd0, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5};
localparam logic [2:0] OP_F3  [4] = '{3'd0, 3'd4, 3'd6, 3'd7};

logic     clk;
logic     arst_n;
logic     instr_valid;
word_t    instr;
logic     busy;
logic     retire;
logic     retire_illegal;
reg_idx_t retire_rd_idx;
word_t    retire_rd_val;

// Reference state
word_t    shadow_regs [32];
cnt_t     edge_cnt;
cnt_t     legal_retired;
integer   seed;
int       issued;
int       checked;

// Expected retires in issue order
logic     exp_legal_q [$];
reg_idx_t exp_rd_q    [$];
word_t    exp_val_q   [$];

letc_core_top i_letc_core_top (
    .clk            (clk),
    .arst_n         (arst_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .busy           (busy),
    .retire         (retire),
    .retire_illegal (retire_illegal),
    .retire_rd_idx  (retire_rd_idx),
    .retire_rd_val  (retire_rd_val)
);

initial clk = 1'b0;
always #20 clk = ~clk;

// Edges since reset release as the cycle CSR counts them
always @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        edge_cnt <= '0;
    end else begin
        edge_cnt <= edge_cnt + cnt_t'(1);
    end
end

task automatic fail_stop(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "run stopped at first error");
endtask

task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
        fail_stop($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
    end
endtask

task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
    if (got !== exp) begin
        fail_stop($sformatf("[FAIL] %s got 0x%02h expected 0x%02h", name, got, exp));
    end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        fail_stop($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
    end
endtask

function automatic word_t encode_itype(input logic [11:0] imm12, input reg_idx_t rs1,
                                       input logic [2:0] f3, input reg_idx_t rd,
                                       input logic [6:0] opc);
    return {imm12, rs1, f3, rd, opc};
endfunction

function automatic word_t encode_rtype(input logic [6:0] f7, input reg_idx_t rs2,
                                       input reg_idx_t rs1, input logic [2:0] f3,
                                       input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

// Applies the RV32I subset rules and returns the legal flag
function automatic logic ref_execute(input word_t ins, input cnt_t cycle_now,
                                     input cnt_t instret_now, output reg_idx_t rd,
                                     output word_t val);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] csr;
    word_t       a;
    word_t       b;
    logic        legal;
    opc   = ins[6:0];
    f3    = ins[14:12];
    f7    = ins[31:25];
    csr   = ins[31:20];
    rd    = ins[11:7];
    a     = shadow_regs[ins[19:15]];
    legal = 1'b0;
    val   = '0;
    case (opc)
        7'h13: begin
            // Sign-extended I immediate
            b = {{20{ins[31]}}, ins[31:20]};
            // Shifts need the upper immediate clear
            legal = ((f3 == 3'd1) || (f3 == 3'd5)) ? (f7 == 7'h00) : 1'b1;
            case (f3)
                3'd0: val = a + b;
                3'd4: val = a ^ b;
                3'd6: val = a | b;
                3'd7: val = a & b;
                3'd1: val = a << b[4:0];
                3'd5: val = a >> b[4:0];
                default: legal = 1'b0;
            endcase
        end
        7'h33: begin
            b = shadow_regs[ins[24:20]];
            // Only SUB may carry funct7 20 hex
            legal = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0));
            case (f3)
                3'd0: val = (f7 == 7'h20) ? a - b : a + b;
                3'd4: val = a ^ b;
                3'd6: val = a | b;
                3'd7: val = a & b;
                default: legal = 1'b0;
            endcase
        end
        7'h73: begin
            // CSRRS with rs1 = x0 on a counter
            if ((f3 == 3'd2) && (ins[19:15] == 5'd0)) begin
                if (csr == `LETC_CSR_CYCLE) begin
                    legal = 1'b1;
                    val   = cycle_now;
                end else if (csr == `LETC_CSR_INSTRET) begin
                    legal = 1'b1;
                    val   = instret_now;
                end
            end
        end
        default: legal = 1'b0;
    endcase
    if (!legal) begin
        rd  = '0;
        val = '0;
    end
    return legal;
endfunction

// Waits for idle, strobes once, queues the expected retire
task automatic issue(input word_t ins);
    reg_idx_t rd;
    word_t    val;
    logic     legal;
    @(negedge clk);
    while (busy) begin
        @(negedge clk);
    end
    instr_valid = 1'b1;
    instr       = ins;
    @(negedge clk);
    instr_valid = 1'b0;
    instr       = $random(seed);
    // edge_cnt holds the acceptance edge and EXECUTE comes one later
    legal = ref_execute(ins, edge_cnt + cnt_t'(1), legal_retired, rd, val);
    exp_legal_q.push_back(legal);
    exp_rd_q.push_back(rd);
    exp_val_q.push_back(val);
    if (legal) begin
        legal_retired = legal_retired + cnt_t'(1);
        if (rd != '0) begin
            shadow_regs[rd] = val;
        end
    end
    issued++;
endtask

// Holds a strobe for the rest of the busy window
task automatic strobe_while_busy(input word_t junk);
    instr_valid = 1'b1;
    instr       = junk;
    while (busy) begin
        @(negedge clk);
    end
    instr_valid = 1'b0;
endtask

// Compare each retire with the oldest expected one
always @(negedge clk) begin : compare_retire
    logic     e_legal;
    reg_idx_t e_rd;
    word_t    e_val;
    if (arst_n && retire) begin
        if (exp_val_q.size() == 0) begin
            fail_stop("A retire came with no instruction pending");
        end else begin
            e_legal = exp_legal_q.pop_front();
            e_rd    = exp_rd_q.pop_front();
            e_val   = exp_val_q.pop_front();
            check_flag("retire_illegal", retire_illegal, !e_legal);
            check_idx("retire_rd_idx", retire_rd_idx, e_rd);
            check_word("retire_rd_val", retire_rd_val, e_val);
            checked++;
        end
    end
end

initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    fail_stop("Timeout, the DUT stopped retiring instructions");
end

initial begin : stimulus
    word_t       rnd;
    logic [11:0] imm12;
    logic [2:0]  f3;
    logic [6:0]  f7;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    seed          = 64280;
    arst_n        = 1'b0;
    instr_valid   = 1'b0;
    instr         = '0;
    legal_retired = '0;
    issued        = 0;
    checked       = 0;
    for (int i = 0; i < 32; i++) begin
        shadow_regs[i] = '0;
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Random OP-IMM with the upper immediate clear on shifts
    for (int n = 0; n < N_RAND_IMM; n++) begin
        rnd   = $random(seed);
        f3    = IMM_F3[rnd[31:8] % 6];
        rd    = rnd[4:0];
        rs1   = rnd[9:5];
        imm12 = 12'($random(seed));
        if ((f3 == 3'd1) || (f3 == 3'd5)) begin
            imm12 = {7'h00, imm12[4:0]};
        end
        issue(encode_itype(imm12, rs1, f3, rd, 7'h13));
    end

    // Random OP reading back earlier results
    for (int n = 0; n < N_RAND_OP; n++) begin
        rnd = $random(seed);
        f3  = OP_F3[rnd[31:8] % 4];
        f7  = ((f3 == 3'd0) && rnd[15]) ? 7'h20 : 7'h00;
        rd  = rnd[4:0];
        rs1 = rnd[9:5];
        rs2 = rnd[14:10];
        issue(encode_rtype(f7, rs2, rs1, f3, rd));
    end

    // x0 as destination and then as source
    issue(encode_itype(12'h7ff, 5'd5, 3'd0, 5'd0, 7'h13));
    issue(encode_rtype(7'h00, 5'd0, 5'd0, 3'd0, 5'd6));
    issue(encode_itype(12'h123, 5'd0, 3'd6, 5'd7, 7'h13));

    // Illegal encodings that must leave rd 9 unchanged
    issue(encode_rtype(7'h01, 5'd3, 5'd4, 3'd0, 5'd9));
    issue(encode_rtype(7'h20, 5'd3, 5'd4, 3'd4, 5'd9));
    issue(encode_rtype(7'h00, 5'd3, 5'd4, 3'd1, 5'd9));
    issue(encode_itype({7'h20, 5'd3}, 5'd4, 3'd1, 5'd9, 7'h13));
    issue(encode_itype({7'h20, 5'd3}, 5'd4, 3'd5, 5'd9, 7'h13));
    issue(encode_itype(12'h010, 5'd4, 3'd2, 5'd9, 7'h03));
    issue(encode_itype(12'hc01, 5'd0, 3'd2, 5'd9, 7'h73));
    issue(encode_itype(12'hc00, 5'd3, 3'd2, 5'd9, 7'h73));
    issue(encode_rtype(7'h00, 5'd0, 5'd9, 3'd0, 5'd8));

    // Counter reads around legal and illegal retires
    issue(encode_itype(`LETC_CSR_INSTRET, 5'd0, 3'd2, 5'd10, 7'h73));
    issue(encode_itype(`LETC_CSR_CYCLE, 5'd0, 3'd2, 5'd11, 7'h73));
    issue(encode_itype(12'h001, 5'd10, 3'd0, 5'd10, 7'h13));
    issue(encode_itype(12'h000, 5'd0, 3'd1, 5'd0, 7'h73));
    issue(encode_itype(`LETC_CSR_INSTRET, 5'd0, 3'd2, 5'd10, 7'h73));
    issue(encode_itype(`LETC_CSR_CYCLE, 5'd0, 3'd2, 5'd11, 7'h73));

    // Strobes while busy are dropped
    issue(encode_itype(12'h055, 5'd0, 3'd0, 5'd12, 7'h13));
    strobe_while_busy(encode_itype(12'h2aa, 5'd0, 3'd0, 5'd12, 7'h13));
    issue(encode_rtype(7'h00, 5'd0, 5'd12, 3'd0, 5'd13));
    strobe_while_busy(encode_itype(12'h0ff, 5'd0, 3'd6, 5'd13, 7'h13));
    issue(encode_itype(`LETC_CSR_INSTRET, 5'd0, 3'd2, 5'd14, 7'h73));

    // Let the last instruction finish and watch for stray retires
    while (busy) begin
        @(negedge clk);
    end
    repeat (6) @(negedge clk);
    $display("Retired %0d instructions, %0d legal", checked, legal_retired);
    if (checked == issued) begin
        $display("Simulation PASSED");
        $finish;
    end else begin
        fail_stop("Retire count does not match the issued instructions");
    end
end

endmodule : letc_core_tb

// ==== build.f ====
+incdir+hw
hw/riscv_pkg.sv
hw/letc_core_pkg.sv
hw/letc_core_sequencer.sv
hw/letc_core_counters.sv
hw/letc_core_rf.sv
hw/letc_core_alu.sv
hw/letc_core_top.sv
testbench/letc_core_props.sv
testbench/letc_core_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compiles the letc_core testbench with Verilator and runs it once.
# The run counts as passed only if its output holds the pass message.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    -f build.f \
    --top-module letc_core_tb \
    -o sim_letc_core

# A failing run exits nonzero, so the grep below decides the result
sim_out=$(./obj_dir/sim_letc_core) || true
echo "$sim_out"

if grep -q "Simulation PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1
